/* cpuPkg.sv */
// core encodings and types
`default_nettype none

package cpuPkg;

    // instruction field widths
    localparam int regAddrWidth = 5;
    localparam int opcodeWidth  = 6;
    localparam int functWidth   = 6;
    localparam int immWidth     = 16;

    // major opcodes of the supported subset
    typedef enum logic [opcodeWidth-1:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // function field under opSpecial
    typedef enum logic [functWidth-1:0] {
        fnSll  = 6'h00, // all-zero word lands here, treated as nop
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui} aluOpT;

    // operand source in decode
    typedef enum logic [1:0] {fwdReg, fwdEx, fwdWb} fwdSelT;

endpackage

`default_nettype wire

/* fetchUnit.sv */
// instruction fetch
`timescale 1ns/10ps
`default_nettype none

module fetchUnit #(
    parameter int imemWords = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         imemWrEn,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  logic [31:0]                  imemData,
    input  logic                         stall,
    input  logic                         branchTaken,
    input  logic [31:0]                  branchTarget,
    output logic [31:0]                  ifInstr,
    output logic [31:0]                  ifPc
);
    localparam int imemAw = $clog2(imemWords);

    logic [31:0] imem [imemWords];
    logic [31:0] pc;

    // program loading port
    always_ff @(posedge clk) begin
        if (imemWrEn) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget; // redirect from decode
        end else if (run && !stall) begin
            pc <= pc + 32'd4;
        end
    end

    // while halted the decode register sees no-ops
    assign ifInstr = run ? imem[pc[imemAw+1:2]] : '0;
    assign ifPc    = pc;

endmodule

`default_nettype wire

/* idReg.sv */
// fetch to decode register
`timescale 1ns/10ps
`default_nettype none

module idReg (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        wr,
    input  logic [31:0] ifInstr,
    input  logic [31:0] ifPc,
    output logic [31:0] idInstr,
    output logic [31:0] idPc,
    output logic        idValid
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            idInstr <= '0; // wrong-path slot becomes a nop
            idValid <= 1'b0;
        end else if (wr) begin
            idInstr <= ifInstr;
            idValid <= 1'b1;
        end
    end

    // pc is payload only
    always_ff @(posedge clk) begin
        if (wr) begin
            idPc <= ifPc;
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
// general purpose register file
`timescale 1ns/10ps
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rs,
    input  logic [regAddrWidth-1:0] rt,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrDst,
    input  logic [31:0]             wrData,
    output logic [31:0]             busA,
    output logic [31:0]             busB
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrDst != '0) begin
            regs[wrDst] <= wrData;
        end
    end

    // r0 is hardwired
    assign busA = (rs == '0) ? '0 : regs[rs];
    assign busB = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

/* decoder.sv */
// instruction decoder
`timescale 1ns/10ps
`default_nettype none

module decoder
    import cpuPkg::*;
(
    input  logic [31:0] instr,
    output aluOpT       aluOp,
    output logic        aluSrcImm,
    output logic        immZeroExt,
    output logic        memRead,
    output logic        memWrite,
    output logic        regWrite,
    output logic        dstIsRt,
    output logic        isBeq,
    output logic        isBne,
    output logic        usesRs,
    output logic        usesRt
);
    opcodeT op;
    functT  fn;

    assign op = opcodeT'(instr[31 -: opcodeWidth]);
    assign fn = functT'(instr[functWidth-1:0]);

    always_comb begin
        // anything unmatched stays a nop
        aluOp      = aluAdd;
        aluSrcImm  = 1'b0;
        immZeroExt = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        regWrite   = 1'b0;
        dstIsRt    = 1'b0;
        isBeq      = 1'b0;
        isBne      = 1'b0;
        usesRs     = 1'b0;
        usesRt     = 1'b0;
        case (op)
            opSpecial: begin
                regWrite = 1'b1;
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                case (fn)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    default: begin // shifts and unknown functions
                        regWrite = 1'b0;
                        usesRs   = 1'b0;
                        usesRt   = 1'b0;
                    end
                endcase
            end
            opAddiu, opOri, opLui, opLw: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                dstIsRt   = 1'b1;
                usesRs    = (op != opLui); // lui reads nothing
                case (op)
                    opOri:   aluOp = aluOr;
                    opLui:   aluOp = aluLui;
                    default: aluOp = aluAdd; // addiu and lw address
                endcase
                immZeroExt = (op == opOri);
                memRead    = (op == opLw);
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1; // store data
            end
            opBeq, opBne: begin
                isBeq  = (op == opBeq);
                isBne  = (op == opBne);
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hazardForward.sv */
// forwarding and load-use detection
`timescale 1ns/10ps
`default_nettype none

module hazardForward
    import cpuPkg::*;
(
    input  logic [regAddrWidth-1:0] rs,
    input  logic [regAddrWidth-1:0] rt,
    input  logic                    usesRs,
    input  logic                    usesRt,
    input  logic                    exRegWrite,
    input  logic                    exMemRead,
    input  logic [regAddrWidth-1:0] exDst,
    input  logic                    wbRegWrite,
    input  logic [regAddrWidth-1:0] wbDst,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB,
    output logic                    stall
);
    logic exHitA, exHitB;
    logic wbHitA, wbHitB;

    // a load in execute has no result yet
    assign exHitA = exRegWrite && !exMemRead && exDst == rs && rs != '0;
    assign exHitB = exRegWrite && !exMemRead && exDst == rt && rt != '0;
    assign wbHitA = wbRegWrite && wbDst == rs && rs != '0;
    assign wbHitB = wbRegWrite && wbDst == rt && rt != '0;

    // youngest producer first
    assign fwdA = exHitA ? fwdEx : (wbHitA ? fwdWb : fwdReg);
    assign fwdB = exHitB ? fwdEx : (wbHitB ? fwdWb : fwdReg);

    assign stall = exMemRead && exDst != '0 &&
                   ((usesRs && exDst == rs) || (usesRt && exDst == rt));

endmodule

`default_nettype wire

/* decodeStage.sv */
// decode stage with branch resolution
`timescale 1ns/10ps
`default_nettype none

module decodeStage
    import cpuPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             ifInstr,
    input  logic [31:0]             ifPc,
    input  logic                    exRegWrite,
    input  logic                    exMemRead,
    input  logic [regAddrWidth-1:0] exDst,
    input  logic [31:0]             exResult,
    input  logic                    wbRegWrite,
    input  logic [regAddrWidth-1:0] wbDst,
    input  logic [31:0]             wbData,
    output logic                    stall,
    output logic                    branchTaken,
    output logic [31:0]             branchTarget,
    output logic                    idValid,
    output logic [31:0]             opA,
    output logic [31:0]             opB,
    output logic [31:0]             imm32,
    output aluOpT                   aluOp,
    output logic                    aluSrcImm,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    regWrite,
    output logic [regAddrWidth-1:0] dst
);
    logic [31:0]             idInstr, idPc, busA, busB, signImm;
    logic                    slotValid, disWr;
    logic [regAddrWidth-1:0] rs, rt, rd;
    logic [immWidth-1:0]     imm16;
    logic                    immZeroExt, dstIsRt, isBeq, isBne, usesRs, usesRt;
    logic                    decMemRead, decMemWrite, decRegWrite, operandsEqual;
    fwdSelT                  fwdA, fwdB;

    function automatic logic [31:0] pickOperand(input fwdSelT sel, input logic [31:0] rf,
                                                input logic [31:0] ex, input logic [31:0] wb);
        case (sel)
            fwdEx:   return ex;
            fwdWb:   return wb;
            default: return rf;
        endcase
    endfunction

    idReg i_idReg (
        .clk(clk), .reset(reset), .flush(branchTaken), .wr(!stall),
        .ifInstr(ifInstr), .ifPc(ifPc),
        .idInstr(idInstr), .idPc(idPc), .idValid(slotValid)
    );

    assign rs    = idInstr[25 -: regAddrWidth];
    assign rt    = idInstr[20 -: regAddrWidth];
    assign rd    = idInstr[15 -: regAddrWidth];
    assign imm16 = idInstr[immWidth-1:0];

    regFile i_regFile (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt),
        .wrEn(wbRegWrite), .wrDst(wbDst), .wrData(wbData),
        .busA(busA), .busB(busB)
    );

    decoder i_decoder (
        .instr(idInstr), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .immZeroExt(immZeroExt),
        .memRead(decMemRead), .memWrite(decMemWrite), .regWrite(decRegWrite),
        .dstIsRt(dstIsRt), .isBeq(isBeq), .isBne(isBne), .usesRs(usesRs), .usesRt(usesRt)
    );

    hazardForward i_hazardForward (
        .rs(rs), .rt(rt), .usesRs(usesRs), .usesRt(usesRt),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exDst(exDst),
        .wbRegWrite(wbRegWrite), .wbDst(wbDst),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    assign opA = pickOperand(fwdA, busA, exResult, wbData);
    assign opB = pickOperand(fwdB, busB, exResult, wbData);

    assign signImm = {{(32-immWidth){imm16[immWidth-1]}}, imm16};
    assign imm32   = immZeroExt ? {{(32-immWidth){1'b0}}, imm16} : signImm;
    assign dst     = dstIsRt ? rt : rd;

    // branches resolve here on forwarded operands
    assign operandsEqual = (opA == opB);
    assign branchTarget  = idPc + 32'd4 + {signImm[29:0], 2'b00};
    assign branchTaken   = slotValid && !stall &&
                           ((isBeq && operandsEqual) || (isBne && !operandsEqual));

    // bubble towards execute
    assign disWr    = stall || !slotValid;
    assign idValid  = !disWr;
    assign memRead  = disWr ? 1'b0 : decMemRead;
    assign memWrite = disWr ? 1'b0 : decMemWrite;
    assign regWrite = disWr ? 1'b0 : decRegWrite;

endmodule

`default_nettype wire

/* executeStage.sv */
// execute, data memory and writeback
`timescale 1ns/10ps
`default_nettype none

module executeStage
    import cpuPkg::*;
#(
    parameter int dmemWords = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    idValid,
    input  logic [31:0]             opA,
    input  logic [31:0]             opB,
    input  logic [31:0]             imm32,
    input  aluOpT                   aluOp,
    input  logic                    aluSrcImm,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    regWrite,
    input  logic [regAddrWidth-1:0] dst,
    output logic                    exRegWrite,
    output logic                    exMemRead,
    output logic [regAddrWidth-1:0] exDst,
    output logic [31:0]             exResult,
    output logic                    wbRegWrite,
    output logic [regAddrWidth-1:0] wbDst,
    output logic [31:0]             wbData,
    output logic                    wbValid
);
    localparam int dmemAw = $clog2(dmemWords);

    logic [31:0] dmem [dmemWords];
    logic [31:0] exOpA, exOpB, exImm, aluB, wbAlu, memRdData;
    logic        exMemWrite, exAluSrcImm, wbFromMem;
    aluOpT       exAluOp;

    always_ff @(posedge clk) begin
        if (reset) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    // operands only move for real instructions
    always_ff @(posedge clk) begin
        if (idValid) begin
            exOpA       <= opA;
            exOpB       <= opB;
            exImm       <= imm32;
            exAluOp     <= aluOp;
            exAluSrcImm <= aluSrcImm;
            exDst       <= dst;
        end
    end

    assign aluB = exAluSrcImm ? exImm : exOpB;

    always_comb begin
        case (exAluOp)
            aluAdd:  exResult = exOpA + aluB;
            aluSub:  exResult = exOpA - aluB;
            aluAnd:  exResult = exOpA & aluB;
            aluOr:   exResult = exOpA | aluB;
            aluXor:  exResult = exOpA ^ aluB;
            aluSlt:  exResult = {31'b0, $signed(exOpA) < $signed(aluB)};
            aluLui:  exResult = {aluB[15:0], 16'b0};
            default: exResult = '0;
        endcase
    end

    // word addressed, upper address bits ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMemWrite) begin
            dmem[exResult[dmemAw+1:2]] <= exOpB;
        end
    end

    always_ff @(posedge clk) begin
        memRdData <= dmem[exResult[dmemAw+1:2]];
        wbAlu     <= exResult;
        wbDst     <= exDst;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            wbFromMem  <= 1'b0;
        end else begin
            wbRegWrite <= exRegWrite;
            wbFromMem  <= exMemRead;
        end
    end

    assign wbData  = wbFromMem ? memRdData : wbAlu;
    assign wbValid = wbRegWrite && wbDst != '0; // r0 writes are invisible

endmodule

`default_nettype wire

/* miniPipe.sv */
// four stage pipeline top
`timescale 1ns/10ps
`default_nettype none

module miniPipe
    import cpuPkg::*;
#(
    parameter int imemWords = 64,
    parameter int dmemWords = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         imemWrEn,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  logic [31:0]                  imemData,
    output logic                         wbValid,
    output logic [regAddrWidth-1:0]      wbDst,
    output logic [31:0]                  wbResult
);
    logic [31:0]             ifInstr, ifPc, branchTarget;
    logic                    stall, branchTaken, idValid;
    logic [31:0]             opA, opB, imm32, exResult;
    aluOpT                   aluOp;
    logic                    aluSrcImm, memRead, memWrite, regWrite;
    logic [regAddrWidth-1:0] dst, exDst;
    logic                    exRegWrite, exMemRead, wbRegWrite;

    fetchUnit #(.imemWords(imemWords)) i_fetchUnit (
        .clk(clk), .reset(reset), .run(run),
        .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .ifInstr(ifInstr), .ifPc(ifPc)
    );

    decodeStage i_decodeStage (
        .clk(clk), .reset(reset), .ifInstr(ifInstr), .ifPc(ifPc),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exDst(exDst), .exResult(exResult),
        .wbRegWrite(wbRegWrite), .wbDst(wbDst), .wbData(wbResult),
        .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .idValid(idValid), .opA(opA), .opB(opB), .imm32(imm32), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .memRead(memRead), .memWrite(memWrite),
        .regWrite(regWrite), .dst(dst)
    );

    executeStage #(.dmemWords(dmemWords)) i_executeStage (
        .clk(clk), .reset(reset), .idValid(idValid), .opA(opA), .opB(opB),
        .imm32(imm32), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .memRead(memRead),
        .memWrite(memWrite), .regWrite(regWrite), .dst(dst),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exDst(exDst), .exResult(exResult),
        .wbRegWrite(wbRegWrite), .wbDst(wbDst), .wbData(wbResult), .wbValid(wbValid)
    );

endmodule

`default_nettype wire

/* tbClockGen.sv */
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
    parameter int periodNs    = 10,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release on a falling edge, like the other stimulus
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* miniPipe_chk.sv */
// pipeline control checks
`timescale 1ns/10ps
`default_nettype none

module miniPipe_chk (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic branchTaken,
    input logic idValid,
    input logic exRegWrite,
    input logic exMemRead
);
    int violations = 0; // failed assertions so far

    // a load-use bubble is a single cycle
    stallOnce: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else begin
            violations++;
            $error("stall held for two consecutive cycles");
        end

    // the stalled slot reaches execute as a bubble
    stallBubble: assert property (@(posedge clk) disable iff (reset)
                                  stall |=> !exRegWrite && !exMemRead)
        else begin
            violations++;
            $error("stalled instruction entered execute");
        end

    // nothing issues from the slot behind a taken branch
    flushedSlot: assert property (@(posedge clk) disable iff (reset) branchTaken |=> !idValid)
        else begin
            violations++;
            $error("wrong-path instruction issued after a taken branch");
        end

endmodule

bind miniPipe miniPipe_chk i_chk (
    .clk(clk), .reset(reset), .stall(stall), .branchTaken(branchTaken),
    .idValid(idValid), .exRegWrite(exRegWrite), .exMemRead(exMemRead)
);

`default_nettype wire

/* tbMiniPipe.sv */
// pipeline core testbench
`timescale 1ns/10ps
`default_nettype none

module tbMiniPipe
    import cpuPkg::*;
;
    localparam int imemWords = 64;
    localparam int dmemWords = 32;
    localparam int imemAw    = $clog2(imemWords);
    localparam int dmemAw    = $clog2(dmemWords);

    logic                    clk, reset, run, imemWrEn;
    logic [imemAw-1:0]       imemAddr;
    logic [31:0]             imemData;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbDst;
    logic [31:0]             wbResult;

    logic [31:0]             prog [imemWords];
    logic [15:0]             lfsr;
    logic [regAddrWidth-1:0] expDst [$];
    logic [31:0]             expVal [$];
    int                      expCount   = 0;
    int                      seenCount  = 0;
    int                      errorCount = 0;

    tbClockGen #(.periodNs(10), .resetCycles(5)) i_tbClockGen (.clk(clk), .reset(reset));

    miniPipe #(.imemWords(imemWords), .dmemWords(dmemWords)) i_miniPipe (
        .clk(clk), .reset(reset), .run(run),
        .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbDst(wbDst), .wbResult(wbResult)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val  = {val[30:0], lfsr[0]}; // one step per bit
        end
    endtask

    // registers 0..7 only, so hazards come often
    task automatic makeInstr(output logic [31:0] ins);
        logic [31:0] kind, rs, rt, rd, sel, imm;
        logic [5:0]  funct;
        drawBits(3, kind);
        drawBits(3, rs);
        drawBits(3, rt);
        drawBits(3, rd);
        case (kind[2:0])
            3'd0, 3'd1: begin
                drawBits(3, sel);
                case (sel[2:0])
                    3'd0:    funct = 6'h21; // addu
                    3'd1:    funct = 6'h23; // subu
                    3'd2:    funct = 6'h24;
                    3'd3:    funct = 6'h25;
                    3'd4:    funct = 6'h26;
                    default: funct = 6'h2a; // slt
                endcase
                ins = {6'h00, 2'b00, rs[2:0], 2'b00, rt[2:0], 2'b00, rd[2:0], 5'd0, funct};
            end
            3'd2, 3'd3, 3'd4: begin
                drawBits(16, imm);
                case (kind[2:0])
                    3'd2:    ins = {6'h09, 2'b00, rs[2:0], 2'b00, rt[2:0], imm[15:0]};
                    3'd3:    ins = {6'h0d, 2'b00, rs[2:0], 2'b00, rt[2:0], imm[15:0]};
                    default: ins = {6'h0f, 5'd0, 2'b00, rt[2:0], imm[15:0]};
                endcase
            end
            3'd5, 3'd6: begin
                drawBits(dmemAw, imm); // word index, base r0
                ins = {(kind[0] ? 6'h23 : 6'h2b), 5'd0, 2'b00, rt[2:0], imm[13:0], 2'b00};
            end
            default: begin
                drawBits(1, sel);
                drawBits(3, imm); // forward offset only
                ins = {(sel[0] ? 6'h05 : 6'h04), 2'b00, rs[2:0], 2'b00, rt[2:0], 13'd0, imm[2:0]};
            end
        endcase
    endtask

    // instruction-set model, one instruction per step, no pipeline
    function automatic int runModel();
        logic [31:0]             regs [32];
        logic [31:0]             mem [dmemWords];
        logic [31:0]             ins, a, b, se, res;
        logic [dmemAw-1:0]       idx;
        logic [regAddrWidth-1:0] d;
        logic                    wr;
        int                      pc;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < dmemWords; i++) mem[i] = '0;
        pc = 0;
        while (pc < imemWords) begin
            ins = prog[pc];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            se  = {{16{ins[15]}}, ins[15:0]};
            idx = dmemAw'((a + se) >> 2);
            d   = ins[20:16];
            wr  = 1'b1;
            res = '0;
            pc  = pc + 1;
            case (ins[31:26])
                6'h00: begin
                    d = ins[15:11];
                    case (ins[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0; // nop word
                    endcase
                end
                6'h09: res = a + se;
                6'h0d: res = a | {16'h0000, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0000};
                6'h23: res = mem[idx];
                6'h2b: begin
                    mem[idx] = b;
                    wr = 1'b0;
                end
                6'h04, 6'h05: begin
                    if ((a == b) == (ins[26] == 1'b0)) pc = pc + int'($signed(se));
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && d != '0) begin
                regs[d] = res;
                expDst.push_back(d);
                expVal.push_back(res);
            end
        end
        return expDst.size();
    endfunction

    // outputs are registered, so the falling edge is a stable point
    always @(negedge clk) begin
        if (!reset && wbValid) begin
            assert (seenCount < expCount) else begin
                errorCount++;
                $display("unexpected writeback to r%0d after the model trace ended", wbDst);
            end
            if (seenCount < expCount) begin
                assert (wbDst == expDst[seenCount]) else begin
                    errorCount++;
                    $display("** Error: wbDst = 0x%0h, expected 0x%0h (writeback %0d)",
                             wbDst, expDst[seenCount], seenCount);
                end
                assert (wbResult == expVal[seenCount]) else begin
                    errorCount++;
                    $display("** Error: wbResult = 0x%08h, expected 0x%08h (writeback %0d)",
                             wbResult, expVal[seenCount], seenCount);
                end
            end
            seenCount++;
        end
    end

    initial begin
        repeat (4 * imemWords + 100) @(posedge clk);
        $display("timeout: %0d of %0d expected writebacks never arrived",
                 expCount - seenCount, expCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] word;
        int          chkFails;
        run      = 1'b0;
        imemWrEn = 1'b0;
        imemAddr = '0;
        imemData = '0;
        lfsr     = 16'd75;
        for (int i = 0; i < imemWords; i++) begin
            if (i < imemWords - 8) makeInstr(word);
            else word = '0; // tail of nops
            prog[i] = word;
        end
        expCount = runModel();

        wait (!reset);
        for (int i = 0; i < imemWords; i++) begin
            @(negedge clk);
            imemWrEn = 1'b1;
            imemAddr = i[imemAw-1:0];
            imemData = prog[i];
        end
        @(negedge clk);
        imemWrEn = 1'b0;
        run      = 1'b1;

        wait (seenCount >= expCount);
        repeat (2) @(negedge clk); // catch stray retirements
        chkFails = i_miniPipe.i_chk.violations;
        $display("writebacks %0d of %0d, mismatches %0d, checker failures %0d",
                 seenCount, expCount, errorCount, chkFails);
        if (errorCount == 0 && chkFails == 0 && seenCount == expCount) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
cpuPkg.sv
fetchUnit.sv
idReg.sv
regFile.sv
decoder.sv
hazardForward.sv
decodeStage.sv
executeStage.sv
miniPipe.sv
tbClockGen.sv
miniPipe_chk.sv
tbMiniPipe.sv

/* run.sh */
#!/bin/sh
# build and run the miniPipe testbench, pass only if the log holds the pass line
verilator --binary --timing --assert --top-module tbMiniPipe -f filelist.f -o simMiniPipe \
    && ./obj_dir/simMiniPipe +verilator+error+limit+1000 > sim.log 2>&1 \
    ; cat sim.log \
    && grep -qx "Verification passed" sim.log \
    || { echo "simulation failed"; exit 1; }
